// ==== compile.f ====
+incdir+verilog
+incdir+test
verilog/axi_pkg.sv
verilog/aw_master_port.sv
verilog/aw_slave_slot.sv
verilog/b_return_mux.sv
verilog/aw_xbar_top.sv
test/aw_xbar_tb.sv

// ==== Bender.yml ====
package:
  name: aw_xbar

export_include_dirs:
  - verilog

sources:
  # RTL in compile order
  - verilog/axi_pkg.sv
  - verilog/aw_master_port.sv
  - verilog/aw_slave_slot.sv
  - verilog/b_return_mux.sv
  - verilog/aw_xbar_top.sv

  # Testbench
  - target: test
    include_dirs:
      - verilog
      - test
    files:
      - test/aw_xbar_tb.sv

// ==== test/aw_xbar_tb_table.svh ====
`ifndef AW_XBAR_TB_TABLE_SVH
`define AW_XBAR_TB_TABLE_SVH

// Name, address, master ID, length, size, burst,
// slave ready delay in cycles, B response, expected slave, random flag
task automatic load_table();
  // One write per region with regions 2 to F on the last slot
  add_row("region0_incr", 32'h0000_1000, 4'h3, 4'h7, 3'd2,
          axi_pkg::BURST_INCR, 0, 2'b00, 0, 1'b0);
  add_row("region1_wrap", 32'h1000_2040, 4'h5, 4'h3, 3'd3,
          axi_pkg::BURST_WRAP, 2, 2'b01, 1, 1'b0);
  add_row("region2_default", 32'h2000_0000, 4'h9, 4'h0, 3'd2,
          axi_pkg::BURST_FIXED, 1, 2'b10, 2, 1'b0);
  add_row("region_f_default", 32'hF000_00FC, 4'hF, 4'hF, 3'd1,
          axi_pkg::BURST_INCR, 0, 2'b11, 2, 1'b0);

  // Long slave back-pressure
  add_row("slow_ready_s0", 32'h0FFF_FFF0, 4'h0, 4'h1, 3'd2,
          axi_pkg::BURST_INCR, 5, 2'b00, 0, 1'b0);
  add_row("slow_ready_s1", 32'h1ABC_0000, 4'hA, 4'h2, 3'd2,
          axi_pkg::BURST_INCR, 4, 2'b10, 1, 1'b0);
  add_row("slow_ready_default", 32'h7000_0000, 4'hC, 4'h0, 3'd0,
          axi_pkg::BURST_FIXED, 6, 2'b00, 2, 1'b0);
  add_row("region1_top", 32'h1FFF_FFFC, 4'h6, 4'h0, 3'd2,
          axi_pkg::BURST_INCR, 1, 2'b01, 1, 1'b0);

  // Address and ID drawn at run time
  add_row("random_0", 32'h0, 4'h0, 4'h3, 3'd2,
          axi_pkg::BURST_INCR, 0, 2'b00, 0, 1'b1);
  add_row("random_1", 32'h0, 4'h0, 4'h7, 3'd3,
          axi_pkg::BURST_WRAP, 2, 2'b10, 0, 1'b1);
  add_row("random_2", 32'h0, 4'h0, 4'h0, 3'd0,
          axi_pkg::BURST_FIXED, 3, 2'b01, 0, 1'b1);
  add_row("random_3", 32'h0, 4'h0, 4'hF, 3'd1,
          axi_pkg::BURST_INCR, 1, 2'b11, 0, 1'b1);
endtask

`endif

// ==== test/aw_xbar_tb.sv ====
`timescale 1ns/1ns
`include "AXI_define.svh"

module aw_xbar_tb;

  localparam int NUM_SLAVES = 3;
  localparam int TIMEOUT    = 50;

  typedef struct {
    string                     name;
    logic [`AXI_ADDR_BITS-1:0] addr;
    logic [`AXI_ID_BITS-1:0]   id;
    logic [`AXI_LEN_BITS-1:0]  len;
    logic [`AXI_SIZE_BITS-1:0] size;
    axi_pkg::burst_t           burst;
    int                        delay;
    logic [1:0]                resp;
    int                        slave;
    bit                        rnd;
    logic [`AXI_IDS_BITS-1:0]  seen_id;
  } row_t;

  logic                                      clk;
  logic                                      rstn;
  logic [`AXI_ID_BITS-1:0]                   aw_id_m;
  logic [`AXI_ADDR_BITS-1:0]                 aw_addr_m;
  logic [`AXI_LEN_BITS-1:0]                  aw_len_m;
  logic [`AXI_SIZE_BITS-1:0]                 aw_size_m;
  axi_pkg::burst_t                           aw_burst_m;
  logic                                      aw_valid_m;
  logic                                      aw_ready_m;
  logic                                      b_valid_m;
  logic [`AXI_ID_BITS-1:0]                   b_id_m;
  logic [1:0]                                b_resp_m;
  logic                                      b_ready_m;
  logic [NUM_SLAVES-1:0][`AXI_IDS_BITS-1:0]  aw_id_s;
  logic [NUM_SLAVES-1:0][`AXI_ADDR_BITS-1:0] aw_addr_s;
  logic [NUM_SLAVES-1:0][`AXI_LEN_BITS-1:0]  aw_len_s;
  logic [NUM_SLAVES-1:0][`AXI_SIZE_BITS-1:0] aw_size_s;
  axi_pkg::burst_t [NUM_SLAVES-1:0]          aw_burst_s;
  logic [NUM_SLAVES-1:0]                     aw_valid_s;
  logic [NUM_SLAVES-1:0]                     aw_ready_s;
  logic [NUM_SLAVES-1:0]                     b_valid_s;
  logic [NUM_SLAVES-1:0][`AXI_IDS_BITS-1:0]  b_id_s;
  logic [NUM_SLAVES-1:0][1:0]                b_resp_s;
  logic [NUM_SLAVES-1:0]                     b_ready_s;

  row_t        rows[$];
  string       tname[$];
  int          terr[$];
  int          pass_count;
  int          fail_count;
  bit          timed_out;
  integer      seed;
  logic [31:0] rand_word;

  aw_xbar_top #(
    .NUM_SLAVES(NUM_SLAVES)
  ) DUT (
    .clk       (clk),
    .rstn      (rstn),
    .aw_id_m   (aw_id_m),
    .aw_addr_m (aw_addr_m),
    .aw_len_m  (aw_len_m),
    .aw_size_m (aw_size_m),
    .aw_burst_m(aw_burst_m),
    .aw_valid_m(aw_valid_m),
    .aw_ready_m(aw_ready_m),
    .b_valid_m (b_valid_m),
    .b_id_m    (b_id_m),
    .b_resp_m  (b_resp_m),
    .b_ready_m (b_ready_m),
    .aw_id_s   (aw_id_s),
    .aw_addr_s (aw_addr_s),
    .aw_len_s  (aw_len_s),
    .aw_size_s (aw_size_s),
    .aw_burst_s(aw_burst_s),
    .aw_valid_s(aw_valid_s),
    .aw_ready_s(aw_ready_s),
    .b_valid_s (b_valid_s),
    .b_id_s    (b_id_s),
    .b_resp_s  (b_resp_s),
    .b_ready_s (b_ready_s)
  );

  always #4 clk = ~clk;

  function automatic void add_row(string name, logic [`AXI_ADDR_BITS-1:0] addr,
                                  logic [`AXI_ID_BITS-1:0] id, logic [`AXI_LEN_BITS-1:0] len,
                                  logic [`AXI_SIZE_BITS-1:0] size, axi_pkg::burst_t burst,
                                  int delay, logic [1:0] resp, int slave, bit rnd);
    row_t row;
    row.name    = name;
    row.addr    = addr;
    row.id      = id;
    row.len     = len;
    row.size    = size;
    row.burst   = burst;
    row.delay   = delay;
    row.resp    = resp;
    row.slave   = slave;
    row.rnd     = rnd;
    row.seen_id = '0;
    rows.push_back(row);
  endfunction

  `include "aw_xbar_tb_table.svh"

  // Slots below the last own one region each and the rest go to the default
  function automatic int region_slave(logic [`AXI_ADDR_BITS-1:0] addr);
    logic [3:0] region;
    region = addr[`AXI_ADDR_BITS-1 -: 4];
    if (int'(region) < NUM_SLAVES - 1) begin
      return int'(region);
    end
    return NUM_SLAVES - 1;
  endfunction

  task automatic compare(int t, string what, logic [31:0] exp, logic [31:0] act);
    assert (exp === act) else begin
      $display("Error %s: %s expected %0h actual %0h", tname[t], what, exp, act);
      terr[t]++;
    end
  endtask

  task automatic finish_test(int t);
    if (terr[t] == 0) begin
      pass_count++;
      $display("PASS %s", tname[t]);
    end else begin
      fail_count++;
      $display("FAIL %s with %0d errors", tname[t], terr[t]);
    end
  endtask

  task automatic report_timeout(int t, string what);
    $display("Timeout in %s, %s never went high", tname[t], what);
    terr[t]++;
    timed_out = 1'b1;
    finish_test(t);
  endtask

  task automatic check_slave_outputs(int r);
    int t;
    t = r + 1;
    for (int s = 0; s < NUM_SLAVES; s++) begin
      if (s == rows[r].slave) begin
        compare(t, $sformatf("aw_valid_s[%0d]", s), 1, aw_valid_s[s]);
        compare(t, $sformatf("aw_id_s[%0d]", s), {axi_pkg::MASTER_1_ID, rows[r].id},
                aw_id_s[s]);
        compare(t, $sformatf("aw_addr_s[%0d]", s), rows[r].addr, aw_addr_s[s]);
        compare(t, $sformatf("aw_len_s[%0d]", s), rows[r].len, aw_len_s[s]);
        compare(t, $sformatf("aw_size_s[%0d]", s), rows[r].size, aw_size_s[s]);
        compare(t, $sformatf("aw_burst_s[%0d]", s), rows[r].burst, aw_burst_s[s]);
      end else begin
        compare(t, $sformatf("aw_valid_s[%0d]", s), 0, aw_valid_s[s]);
        compare(t, $sformatf("aw_id_s[%0d]", s), 0, aw_id_s[s]);
        compare(t, $sformatf("aw_addr_s[%0d]", s), 0, aw_addr_s[s]);
        compare(t, $sformatf("aw_len_s[%0d]", s), 0, aw_len_s[s]);
        compare(t, $sformatf("aw_size_s[%0d]", s), 0, aw_size_s[s]);
        compare(t, $sformatf("aw_burst_s[%0d]", s), 0, aw_burst_s[s]);
      end
    end
  endtask

  // Master request with every slave ready high while a write is outstanding
  task automatic drive_aw(int r, bit all_ready);
    aw_id_m    = rows[r].id;
    aw_addr_m  = rows[r].addr;
    aw_len_m   = rows[r].len;
    aw_size_m  = rows[r].size;
    aw_burst_m = rows[r].burst;
    aw_valid_m = 1'b1;
    aw_ready_s = all_ready ? '1 : '0;
  endtask

  task automatic accept_aw(int r);
    int cnt;
    int s;
    s = rows[r].slave;
    aw_ready_s = '0;
    repeat (rows[r].delay) begin
      @(negedge clk);
      check_slave_outputs(r);
      compare(r + 1, "aw_ready_m", 0, aw_ready_m);
      @(posedge clk);
      #1;
    end
    aw_ready_s[s] = 1'b1;
    cnt = 0;
    @(negedge clk);
    while (aw_ready_m !== 1'b1 && cnt < TIMEOUT) begin
      @(negedge clk);
      cnt++;
    end
    if (aw_ready_m !== 1'b1) begin
      report_timeout(r + 1, "aw_ready_m");
      return;
    end
    // AW path is combinational
    compare(r + 1, "aw_ready_m wait cycles", 0, cnt);
    check_slave_outputs(r);
    rows[r].seen_id = aw_id_s[s];
    @(posedge clk);
    #1;
    aw_valid_m = 1'b0;
    aw_id_m    = '0;
    aw_addr_m  = '0;
    aw_len_m   = '0;
    aw_size_m  = '0;
    aw_burst_m = axi_pkg::BURST_FIXED;
    aw_ready_s = '0;
  endtask

  task automatic return_b(int r);
    int cnt;
    int s;
    s = rows[r].slave;
    // Slave echoes the ID it received
    b_valid_s[s] = 1'b1;
    b_id_s[s]    = rows[r].seen_id;
    b_resp_s[s]  = rows[r].resp;
    b_ready_m    = 1'b0;
    cnt = 0;
    @(negedge clk);
    while (b_valid_m !== 1'b1 && cnt < TIMEOUT) begin
      @(negedge clk);
      cnt++;
    end
    if (b_valid_m !== 1'b1) begin
      report_timeout(r + 1, "b_valid_m");
      return;
    end
    compare(r + 1, "b_valid_m wait cycles", 0, cnt);
    compare(r + 1, "b_id_m", rows[r].id, b_id_m);
    compare(r + 1, "b_resp_m", rows[r].resp, b_resp_m);
    compare(r + 1, "b_ready_s", 0, b_ready_s);
    compare(r + 1, "aw_ready_m", 0, aw_ready_m);
    @(posedge clk);
    #1;
    b_ready_m = 1'b1;
    @(negedge clk);
    compare(r + 1, "b_valid_m", 1, b_valid_m);
    compare(r + 1, "b_ready_s", 1 << s, b_ready_s);
    @(posedge clk);
    #1;
    b_valid_s = '0;
    b_id_s    = '0;
    b_resp_s  = '0;
    b_ready_m = 1'b0;
  endtask

  task automatic retire_row(int r);
    repeat (3) begin
      @(negedge clk);
      compare(r + 1, "aw_ready_m", 0, aw_ready_m);
      compare(r + 1, "aw_valid_s", 0, aw_valid_s);
      @(posedge clk);
      #1;
    end
    return_b(r);
    if (!timed_out) begin
      finish_test(r + 1);
    end
  endtask

  initial begin
    seed       = 32'h3696_6fdc;
    clk        = 1'b0;
    rstn       = 1'b0;
    aw_id_m    = '0;
    aw_addr_m  = '0;
    aw_len_m   = '0;
    aw_size_m  = '0;
    aw_burst_m = axi_pkg::BURST_FIXED;
    aw_valid_m = 1'b0;
    b_ready_m  = 1'b0;
    aw_ready_s = '0;
    b_valid_s  = '0;
    b_id_s     = '0;
    b_resp_s   = '0;
    pass_count = 0;
    fail_count = 0;
    timed_out  = 1'b0;

    load_table();
    tname.push_back("reset_values");
    terr.push_back(0);
    for (int r = 0; r < rows.size(); r++) begin
      if (rows[r].rnd) begin
        rand_word     = $random(seed);
        rows[r].addr  = rand_word;
        rand_word     = $random(seed);
        rows[r].id    = rand_word[`AXI_ID_BITS-1:0];
        rows[r].slave = region_slave(rows[r].addr);
      end
      tname.push_back(rows[r].name);
      terr.push_back(0);
    end

    repeat (8) @(posedge clk);
    #1;
    // Slaves busy across the reset release
    aw_ready_s = '1;
    b_valid_s  = '1;
    b_id_s     = {NUM_SLAVES{axi_pkg::MASTER_1_ID, {`AXI_ID_BITS{1'b0}}}};
    b_ready_m  = 1'b1;
    rstn       = 1'b1;
    @(negedge clk);
    compare(0, "aw_ready_m", 0, aw_ready_m);
    compare(0, "b_valid_m", 0, b_valid_m);
    compare(0, "aw_valid_s", 0, aw_valid_s);
    compare(0, "b_ready_s", 0, b_ready_s);
    finish_test(0);
    @(posedge clk);
    #1;
    aw_ready_s = '0;
    b_valid_s  = '0;
    b_id_s     = '0;
    b_ready_m  = 1'b0;

    // Next request waits at the master while the previous B is still out
    for (int r = 0; r < rows.size(); r++) begin
      drive_aw(r, r > 0);
      if (r > 0) begin
        retire_row(r - 1);
        if (timed_out) break;
      end
      accept_aw(r);
      if (timed_out) break;
    end
    if (!timed_out && rows.size() > 0) begin
      aw_ready_s = '1;
      retire_row(rows.size() - 1);
    end

    $display("Tests passed %0d, failed %0d", pass_count, fail_count);
    if (fail_count == 0 && !timed_out) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== verilog/aw_xbar_top.sv ====
`timescale 1ns/1ns
`include "AXI_define.svh"

module aw_xbar_top #(
  parameter int NUM_SLAVES = 3
) (
  input  logic                                      clk,
  input  logic                                      rstn,
  // Master AW channel
  input  logic [`AXI_ID_BITS-1:0]                   aw_id_m,
  input  logic [`AXI_ADDR_BITS-1:0]                 aw_addr_m,
  input  logic [`AXI_LEN_BITS-1:0]                  aw_len_m,
  input  logic [`AXI_SIZE_BITS-1:0]                 aw_size_m,
  input  axi_pkg::burst_t                           aw_burst_m,
  input  logic                                      aw_valid_m,
  output logic                                      aw_ready_m,
  // Master B channel
  output logic                                      b_valid_m,
  output logic [`AXI_ID_BITS-1:0]                   b_id_m,
  output logic [1:0]                                b_resp_m,
  input  logic                                      b_ready_m,
  // Slave AW channels with the default slave last
  output logic [NUM_SLAVES-1:0][`AXI_IDS_BITS-1:0]  aw_id_s,
  output logic [NUM_SLAVES-1:0][`AXI_ADDR_BITS-1:0] aw_addr_s,
  output logic [NUM_SLAVES-1:0][`AXI_LEN_BITS-1:0]  aw_len_s,
  output logic [NUM_SLAVES-1:0][`AXI_SIZE_BITS-1:0] aw_size_s,
  output axi_pkg::burst_t [NUM_SLAVES-1:0]          aw_burst_s,
  output logic [NUM_SLAVES-1:0]                     aw_valid_s,
  input  logic [NUM_SLAVES-1:0]                     aw_ready_s,
  // Slave B channels
  input  logic [NUM_SLAVES-1:0]                     b_valid_s,
  input  logic [NUM_SLAVES-1:0][`AXI_IDS_BITS-1:0]  b_id_s,
  input  logic [NUM_SLAVES-1:0][1:0]                b_resp_s,
  output logic [NUM_SLAVES-1:0]                     b_ready_s
);

  logic [`AXI_IDS_BITS-1:0]  aw_id_x;
  logic [`AXI_ADDR_BITS-1:0] aw_addr_x;
  logic [`AXI_LEN_BITS-1:0]  aw_len_x;
  logic [`AXI_SIZE_BITS-1:0] aw_size_x;
  axi_pkg::burst_t           aw_burst_x;
  logic                      aw_valid_x;
  logic [NUM_SLAVES-1:0]     slave_sel;
  logic [NUM_SLAVES-1:0]     ready_gated;
  logic [NUM_SLAVES-1:0]     pending;
  logic                      slave_ready;

  aw_master_port #(
    .NUM_SLAVES(NUM_SLAVES)
  ) u_master_port (
    .clk        (clk),
    .rstn       (rstn),
    .aw_id_m    (aw_id_m),
    .aw_addr_m  (aw_addr_m),
    .aw_len_m   (aw_len_m),
    .aw_size_m  (aw_size_m),
    .aw_burst_m (aw_burst_m),
    .aw_valid_m (aw_valid_m),
    .aw_ready_m (aw_ready_m),
    .b_valid_m  (b_valid_m),
    .b_ready_m  (b_ready_m),
    .slave_ready(slave_ready),
    .aw_id_x    (aw_id_x),
    .aw_addr_x  (aw_addr_x),
    .aw_len_x   (aw_len_x),
    .aw_size_x  (aw_size_x),
    .aw_burst_x (aw_burst_x),
    .aw_valid_x (aw_valid_x),
    .slave_sel  (slave_sel)
  );

  // One slot per slave port
  for (genvar i = 0; i < NUM_SLAVES; i++) begin : g_slot
    aw_slave_slot u_slot (
      .clk        (clk),
      .rstn       (rstn),
      .aw_id_x    (aw_id_x),
      .aw_addr_x  (aw_addr_x),
      .aw_len_x   (aw_len_x),
      .aw_size_x  (aw_size_x),
      .aw_burst_x (aw_burst_x),
      .aw_valid_x (aw_valid_x),
      .sel        (slave_sel[i]),
      .aw_id_s    (aw_id_s[i]),
      .aw_addr_s  (aw_addr_s[i]),
      .aw_len_s   (aw_len_s[i]),
      .aw_size_s  (aw_size_s[i]),
      .aw_burst_s (aw_burst_s[i]),
      .aw_valid_s (aw_valid_s[i]),
      .aw_ready   (aw_ready_s[i]),
      .ready_gated(ready_gated[i]),
      .b_valid    (b_valid_s[i]),
      .b_ready    (b_ready_s[i]),
      .pending    (pending[i])
    );
  end

  b_return_mux #(
    .NUM_SLAVES(NUM_SLAVES)
  ) u_b_return (
    .ready_gated(ready_gated),
    .pending    (pending),
    .b_valid_s  (b_valid_s),
    .b_id_s     (b_id_s),
    .b_resp_s   (b_resp_s),
    .b_ready_s  (b_ready_s),
    .slave_ready(slave_ready),
    .b_valid_m  (b_valid_m),
    .b_id_m     (b_id_m),
    .b_resp_m   (b_resp_m),
    .b_ready_m  (b_ready_m)
  );

endmodule

// ==== verilog/b_return_mux.sv ====
`timescale 1ns/1ns
`include "AXI_define.svh"

module b_return_mux #(
  parameter int NUM_SLAVES = 3
) (
  input  logic [NUM_SLAVES-1:0]                     ready_gated,
  input  logic [NUM_SLAVES-1:0]                     pending,
  // B channels of the slaves
  input  logic [NUM_SLAVES-1:0]                     b_valid_s,
  input  logic [NUM_SLAVES-1:0][`AXI_IDS_BITS-1:0] b_id_s,
  input  logic [NUM_SLAVES-1:0][1:0]               b_resp_s,
  output logic [NUM_SLAVES-1:0]                     b_ready_s,
  // Ready back to the arbiter
  output logic                                      slave_ready,
  // B channel of the master
  output logic                                      b_valid_m,
  output logic [`AXI_ID_BITS-1:0]                   b_id_m,
  output logic [1:0]                                b_resp_m,
  input  logic                                      b_ready_m
);

  logic                     b_valid_sel;
  logic [`AXI_IDS_BITS-1:0] b_id_sel;
  logic [1:0]               b_resp_sel;
  logic                     id_match;

  // Only the selected slot passes a nonzero ready
  assign slave_ready = |ready_gated;

  // At most one slot is pending at a time
  always_comb begin
    b_valid_sel = 1'b0;
    b_id_sel    = '0;
    b_resp_sel  = '0;
    for (int i = 0; i < NUM_SLAVES; i++) begin
      if (pending[i]) begin
        b_valid_sel = b_valid_s[i];
        b_id_sel    = b_id_s[i];
        b_resp_sel  = b_resp_s[i];
      end
    end
  end

  // Response must carry the master prefix
  assign id_match = (b_id_sel[`AXI_IDS_BITS-1:`AXI_ID_BITS] == axi_pkg::MASTER_1_ID);

  assign b_valid_m = b_valid_sel & id_match;
  assign b_id_m    = b_id_sel[`AXI_ID_BITS-1:0];
  assign b_resp_m  = b_resp_sel;

  always_comb begin
    for (int i = 0; i < NUM_SLAVES; i++) begin
      b_ready_s[i] = pending[i] & b_ready_m & id_match;
    end
  end

endmodule

// ==== verilog/aw_slave_slot.sv ====
`timescale 1ns/1ns
`include "AXI_define.svh"

module aw_slave_slot (
  input  logic                      clk,
  input  logic                      rstn,
  // Shared payload from the master port
  input  logic [ `AXI_IDS_BITS-1:0] aw_id_x,
  input  logic [`AXI_ADDR_BITS-1:0] aw_addr_x,
  input  logic [ `AXI_LEN_BITS-1:0] aw_len_x,
  input  logic [`AXI_SIZE_BITS-1:0] aw_size_x,
  input  axi_pkg::burst_t           aw_burst_x,
  input  logic                      aw_valid_x,
  input  logic                      sel,
  // AW channel of this slave
  output logic [ `AXI_IDS_BITS-1:0] aw_id_s,
  output logic [`AXI_ADDR_BITS-1:0] aw_addr_s,
  output logic [ `AXI_LEN_BITS-1:0] aw_len_s,
  output logic [`AXI_SIZE_BITS-1:0] aw_size_s,
  output axi_pkg::burst_t           aw_burst_s,
  output logic                      aw_valid_s,
  input  logic                      aw_ready,
  output logic                      ready_gated,
  // B handshake of this slave
  input  logic                      b_valid,
  input  logic                      b_ready,
  output logic                      pending
);

  always_comb begin
    if (sel) begin
      aw_id_s    = aw_id_x;
      aw_addr_s  = aw_addr_x;
      aw_len_s   = aw_len_x;
      aw_size_s  = aw_size_x;
      aw_burst_s = aw_burst_x;
      aw_valid_s = aw_valid_x;
    end else begin
      aw_id_s    = '0;
      aw_addr_s  = '0;
      aw_len_s   = '0;
      aw_size_s  = '0;
      aw_burst_s = axi_pkg::BURST_FIXED;
      aw_valid_s = 1'b0;
    end
  end

  assign ready_gated = aw_ready & sel;

  // Outstanding write at this slave
  always_ff @(posedge clk, negedge rstn) begin
    if (!rstn) begin
      pending <= 1'b0;
    end else if (b_valid && b_ready) begin
      pending <= 1'b0;
    end else if (aw_valid_s && aw_ready) begin
      pending <= 1'b1;
    end
  end

endmodule

// ==== verilog/aw_master_port.sv ====
`timescale 1ns/1ns
`include "AXI_define.svh"

module aw_master_port #(
  parameter int NUM_SLAVES = 3
) (
  input  logic                      clk,
  input  logic                      rstn,
  // Master AW channel
  input  logic [  `AXI_ID_BITS-1:0] aw_id_m,
  input  logic [`AXI_ADDR_BITS-1:0] aw_addr_m,
  input  logic [ `AXI_LEN_BITS-1:0] aw_len_m,
  input  logic [`AXI_SIZE_BITS-1:0] aw_size_m,
  input  axi_pkg::burst_t           aw_burst_m,
  input  logic                      aw_valid_m,
  output logic                      aw_ready_m,
  // B handshake at the master
  input  logic                      b_valid_m,
  input  logic                      b_ready_m,
  // Ready of the selected slave
  input  logic                      slave_ready,
  // Shared payload towards the slots
  output logic [ `AXI_IDS_BITS-1:0] aw_id_x,
  output logic [`AXI_ADDR_BITS-1:0] aw_addr_x,
  output logic [ `AXI_LEN_BITS-1:0] aw_len_x,
  output logic [`AXI_SIZE_BITS-1:0] aw_size_x,
  output axi_pkg::burst_t           aw_burst_x,
  output logic                      aw_valid_x,
  output logic [    NUM_SLAVES-1:0] slave_sel
);

  axi_pkg::aw_lock_t lock_state;
  axi_pkg::aw_lock_t lock_state_next;
  logic              aw_lock;
  logic              pass;
  logic [3:0]        region;
  logic              region_hit;

  always_ff @(posedge clk, negedge rstn) begin
    if (!rstn) begin
      lock_state <= axi_pkg::LOCK_FREE;
    end else begin
      lock_state <= lock_state_next;
    end
  end

  always_comb begin
    lock_state_next = axi_pkg::LOCK_FREE;
    unique case (lock_state)
      axi_pkg::LOCK_FREE: lock_state_next = aw_valid_m ? axi_pkg::LOCK_M1 : axi_pkg::LOCK_FREE;
      axi_pkg::LOCK_M1:   lock_state_next = slave_ready ? axi_pkg::LOCK_FREE : axi_pkg::LOCK_M1;
    endcase
  end

  // Hold AWREADY low while a write is outstanding
  always_ff @(posedge clk, negedge rstn) begin
    if (!rstn) begin
      aw_lock <= 1'b0;
    end else if (aw_lock) begin
      aw_lock <= ~(b_valid_m & b_ready_m);
    end else begin
      aw_lock <= aw_valid_m & aw_ready_m;
    end
  end

  assign pass = (lock_state == axi_pkg::LOCK_M1) || aw_valid_m;

  always_comb begin
    aw_id_x    = '0;
    aw_addr_x  = '0;
    aw_len_x   = '0;
    aw_size_x  = '0;
    aw_burst_x = axi_pkg::BURST_FIXED;
    aw_valid_x = 1'b0;
    aw_ready_m = 1'b0;
    if (pass) begin
      aw_id_x    = {axi_pkg::MASTER_1_ID, aw_id_m};
      aw_addr_x  = aw_addr_m;
      aw_len_x   = aw_len_m;
      aw_size_x  = aw_size_m;
      aw_burst_x = aw_burst_m;
      // No new request reaches a slave until the B response is back
      aw_valid_x = aw_valid_m & ~aw_lock;
      aw_ready_m = slave_ready & ~aw_lock;
    end
  end

  // Unmapped regions fall to the last slot
  assign region = aw_addr_x[axi_pkg::REGION_MSB -: 4];

  always_comb begin
    slave_sel  = '0;
    region_hit = 1'b0;
    for (int i = 0; i < NUM_SLAVES - 1; i++) begin
      if (region == i) begin
        slave_sel[i] = 1'b1;
        region_hit   = 1'b1;
      end
    end
    slave_sel[NUM_SLAVES-1] = ~region_hit;
  end

endmodule

// ==== verilog/axi_pkg.sv ====
package axi_pkg;

  // Arbiter lock state with one live master
  typedef enum logic {
    LOCK_FREE = 1'b0,
    LOCK_M1   = 1'b1
  } aw_lock_t;

  // AXI burst type encoding
  typedef enum logic [1:0] {
    BURST_FIXED = 2'b00,
    BURST_INCR  = 2'b01,
    BURST_WRAP  = 2'b10
  } burst_t;

  // Prefix placed in front of the master ID on the slave side
  localparam logic [3:0] MASTER_1_ID = 4'b0001;

  // Region field sits in the top nibble of the address
  localparam int REGION_MSB = 31;

endpackage

// ==== verilog/AXI_define.svh ====
`ifndef AXI_DEFINE_SVH
`define AXI_DEFINE_SVH

// Master side ID width
`define AXI_ID_BITS 4

// Slave side ID is the master prefix plus the master ID
`define AXI_IDS_BITS 8

`define AXI_ADDR_BITS 32

// Burst length and beat size fields
`define AXI_LEN_BITS 4
`define AXI_SIZE_BITS 3

`endif
